// ==== sim.f ====
+incdir+include
hdl/wb_pkg.sv
hdl/wb_event_sel.sv
hdl/wb_cpsr_ctl.sv
hdl/wb_pc_seq.sv
hdl/wb_regfile.sv
hdl/wb_top.sv
test/tb_wb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the writeback testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
        --top-module tb_wb_top -Mdir obj_dir -o tb_wb_top \
        || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_wb_top > sim.log 2>&1
cat sim.log

grep -qF "*** TEST PASSED ***" sim.log && exit 0 || exit 1

// ==== test/tb_wb_top.sv ====
// ------------------------------
// Table-driven testbench for the writeback stage.
// Rows hold inputs and the outputs seen while each row is applied.
// ------------------------------
`include "wb_params.svh"

module tb_wb_top;

import wb_pkg::*;

// One table row.
// Expected fields describe what the DUT shows during the row.
typedef struct packed {
        logic     stall;
        logic     alu;
        word_t    alu_pc;
        logic     dec;
        word_t    dec_pc;
        logic     valid;
        reg_idx_t wr_index;
        word_t    wr_data;
        cpsr_t    flags;
        logic     mem_load;
        reg_idx_t wr_index_1;
        word_t    wr_data_1;
        wb_exc_t  exc;
        reg_idx_t rd_index;
        logic     chk_rd;
        word_t    exp_rd;
        word_t    exp_pc_nxt;
        word_t    exp_pc;
        cpsr_t    exp_cpsr;
        logic     exp_clear;
        logic     exp_shelve;
        logic     exp_mask;
} row_t;

localparam int    RESET_EDGES      = 10;
localparam int    RESET_WAIT_LIMIT = 16;

// Supervisor mode with IRQ and FIQ masked.
localparam cpsr_t RESET_CPSR = '{mode: svc, i: 1'b1, f: 1'b1, default: '0};

logic     i_clk;
logic     i_reset;
logic     i_valid;
logic     i_code_stall;
logic     i_clear_from_alu;
word_t    i_pc_from_alu;
logic     i_clear_from_decode;
word_t    i_pc_from_decode;
reg_idx_t i_rd_index_0;
reg_idx_t i_rd_index_1;
reg_idx_t i_wr_index;
word_t    i_wr_data;
cpsr_t    i_flags;
logic     i_mem_load;
reg_idx_t i_wr_index_1;
word_t    i_wr_data_1;
logic     i_fiq;
logic     i_irq;
logic     i_swi;
logic     i_und;
word_t    i_pc_buf;

word_t    o_rd_data_0;
word_t    o_rd_data_1;
word_t    o_pc;
word_t    o_pc_nxt;
cpsr_t    o_cpsr;
logic     o_clear_from_writeback;
logic     o_shelve;
logic     o_mask;

row_t     rows [$];
int       mismatch_count = 0;
int       timeout_count  = 0;
logic     reset_ok;

wb_top dut0
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_valid                (i_valid),
        .i_code_stall           (i_code_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_pc_from_decode       (i_pc_from_decode),
        .i_rd_index_0           (i_rd_index_0),
        .i_rd_index_1           (i_rd_index_1),
        .i_wr_index             (i_wr_index),
        .i_wr_data              (i_wr_data),
        .i_flags                (i_flags),
        .i_mem_load             (i_mem_load),
        .i_wr_index_1           (i_wr_index_1),
        .i_wr_data_1            (i_wr_data_1),
        .i_fiq                  (i_fiq),
        .i_irq                  (i_irq),
        .i_swi                  (i_swi),
        .i_und                  (i_und),
        .i_pc_buf               (i_pc_buf),
        .o_rd_data_0            (o_rd_data_0),
        .o_rd_data_1            (o_rd_data_1),
        .o_pc                   (o_pc),
        .o_pc_nxt               (o_pc_nxt),
        .o_cpsr                 (o_cpsr),
        .o_clear_from_writeback (o_clear_from_writeback),
        .o_shelve               (o_shelve),
        .o_mask                 (o_mask)
);

// 8-unit clock.
initial i_clk = 1'b0;
always #4 i_clk = ~i_clk;

// ------------------------------
// Compare tasks
// ------------------------------

task automatic check_word (input string what, input word_t got, input word_t exp);
        if ( got !== exp )
        begin
                $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
                mismatch_count++;
        end
endtask

task automatic check_cpsr (input string what, input cpsr_t got, input cpsr_t exp);
        if ( got !== exp )
        begin
                $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
                mismatch_count++;
        end
endtask

task automatic check_bit (input string what, input logic got, input logic exp);
        if ( got !== exp )
        begin
                $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
                mismatch_count++;
        end
endtask

// ------------------------------
// Table helpers
// ------------------------------

// Fills in the outputs a row expects.
function automatic row_t set_expect
(
        input row_t  r,
        input word_t pc_nxt,
        input word_t pc,
        input cpsr_t cpsr,
        input logic  clear,
        input logic  shelve,
        input logic  mask
);
        row_t e;
        e            = r;
        e.exp_pc_nxt = pc_nxt;
        e.exp_pc     = pc;
        e.exp_cpsr   = cpsr;
        e.exp_clear  = clear;
        e.exp_shelve = shelve;
        e.exp_mask   = mask;
        return e;
endfunction

// Builds the whole scenario.
// PC values follow the sequencing rules by hand; data words are random.
task automatic build_rows;
        row_t  r;
        word_t d_a, d_b, d_c, d_d, d_e, d_f, d_g;
        word_t tgt;
        cpsr_t f1, f2, c_fiq, c_svc;
        d_a = $urandom();
        d_b = $urandom();
        d_c = $urandom();
        d_d = $urandom();
        d_e = $urandom() | 32'd1;
        d_f = $urandom();
        d_g = $urandom();

        // Odd load data, so the jump target lands one below it.
        tgt = d_e - 32'd1;

        f1 = '{n: 1'b1, c: 1'b1, mode: usr, default: '0};
        f2 = '{z: 1'b1, v: 1'b1, mode: usr, default: '0};

        // FIQ entry: mode fiq, both masks set, ARM state.
        c_fiq      = f1;
        c_fiq.mode = fiq;
        c_fiq.i    = 1'b1;
        c_fiq.f    = 1'b1;
        c_fiq.t    = 1'b0;

        // SWI entry keeps f, sets i.
        c_svc      = c_fiq;
        c_svc.mode = svc;
        c_svc.i    = 1'b1;
        c_svc.t    = 1'b0;

        // Reset state, then sequential fetch with a two-cycle stall.
        r = '0;
        rows.push_back(set_expect(r, 32'h0, 32'h0, RESET_CPSR, 0, 0, 0));
        rows.push_back(set_expect(r, 32'h4, 32'h0, RESET_CPSR, 0, 0, 0));
        rows.push_back(set_expect(r, 32'h8, 32'h0, RESET_CPSR, 0, 0, 0));
        r.stall = 1'b1;
        rows.push_back(set_expect(r, 32'hC, 32'h4, RESET_CPSR, 0, 0, 0));
        rows.push_back(set_expect(r, 32'hC, 32'h4, RESET_CPSR, 0, 0, 0));
        r = '0;
        rows.push_back(set_expect(r, 32'hC, 32'h4, RESET_CPSR, 0, 0, 0));

        // Plain commit into r3.
        r = '0;
        r.valid    = 1'b1;
        r.wr_index = 6'd3;
        r.wr_data  = d_a;
        r.flags    = f1;
        rows.push_back(set_expect(r, 32'h10, 32'h8, RESET_CPSR, 0, 0, 0));
        r = '0;
        r.rd_index = 6'd3;
        r.chk_rd   = 1'b1;
        r.exp_rd   = d_a;
        rows.push_back(set_expect(r, 32'h14, 32'hC, f1, 0, 0, 0));

        // Commit with a load into r5.
        r = '0;
        r.valid      = 1'b1;
        r.wr_index   = 6'd4;
        r.wr_data    = d_b;
        r.flags      = f2;
        r.mem_load   = 1'b1;
        r.wr_index_1 = 6'd5;
        r.wr_data_1  = d_c;
        rows.push_back(set_expect(r, 32'h18, 32'h10, f1, 0, 0, 0));
        r = '0;
        r.rd_index = 6'd5;
        r.chk_rd   = 1'b1;
        r.exp_rd   = d_c;
        rows.push_back(set_expect(r, 32'h1C, 32'h14, f2, 0, 0, 0));
        r.rd_index = 6'd4;
        r.exp_rd   = d_b;
        rows.push_back(set_expect(r, 32'h20, 32'h18, f2, 0, 0, 0));

        // Load into the PC flushes and redirects.
        r = '0;
        r.valid      = 1'b1;
        r.wr_index   = 6'd6;
        r.wr_data    = d_d;
        r.flags      = f1;
        r.mem_load   = 1'b1;
        r.wr_index_1 = `WB_ARCH_PC;
        r.wr_data_1  = d_e;
        rows.push_back(set_expect(r, 32'h24, 32'h1C, f2, 1, 0, 0));
        r = '0;
        r.rd_index = `WB_ARCH_PC;
        r.chk_rd   = 1'b1;
        r.exp_rd   = d_e;
        rows.push_back(set_expect(r, tgt, 32'h20, f1, 0, 0, 1));
        r = '0;
        rows.push_back(set_expect(r, tgt + 32'd4, 32'h24, f1, 0, 0, 1));
        rows.push_back(set_expect(r, tgt + 32'd8, tgt, f1, 0, 0, 0));

        // FIQ beats IRQ.
        r = '0;
        r.exc.fiq = 1'b1;
        r.exc.irq = 1'b1;
        r.wr_data = d_f;
        rows.push_back(set_expect(r, tgt + 32'd12, tgt + 32'd4, f1, 1, 0, 0));
        r = '0;
        r.rd_index = `WB_PHY_FIQ_R14;
        r.chk_rd   = 1'b1;
        r.exp_rd   = d_f;
        rows.push_back(set_expect(r, `WB_FIQ_VECTOR, tgt + 32'd8, c_fiq, 0, 0, 1));
        r.rd_index = `WB_PHY_FIQ_SPSR;
        r.exp_rd   = f1;
        rows.push_back(set_expect(r, 32'h20, tgt + 32'd12, c_fiq, 0, 0, 1));

        // SWI alone.
        r = '0;
        r.exc.swi = 1'b1;
        r.wr_data = d_g;
        rows.push_back(set_expect(r, 32'h24, 32'h1C, c_fiq, 1, 0, 0));
        r = '0;
        r.rd_index = `WB_PHY_SVC_R14;
        r.chk_rd   = 1'b1;
        r.exp_rd   = d_g;
        rows.push_back(set_expect(r, `WB_SWI_VECTOR, 32'h20, c_svc, 0, 0, 1));

        // Decode redirect under stall is shelved, then released.
        r = '0;
        r.stall    = 1'b1;
        r.dec      = 1'b1;
        r.dec_pc   = 32'h100;
        r.rd_index = `WB_PHY_SVC_SPSR;
        r.chk_rd   = 1'b1;
        r.exp_rd   = c_fiq;
        rows.push_back(set_expect(r, 32'hC, 32'h24, c_svc, 0, 0, 1));
        r = '0;
        r.stall = 1'b1;
        rows.push_back(set_expect(r, 32'hC, 32'h24, c_svc, 0, 1, 0));
        r = '0;
        rows.push_back(set_expect(r, 32'hC, 32'h24, c_svc, 0, 1, 0));
        rows.push_back(set_expect(r, 32'h100, 32'h8, c_svc, 0, 0, 1));

        // ALU target wins over decode.
        r = '0;
        r.alu    = 1'b1;
        r.alu_pc = 32'h200;
        r.dec    = 1'b1;
        r.dec_pc = 32'h300;
        rows.push_back(set_expect(r, 32'h104, 32'hC, c_svc, 0, 0, 1));
        r = '0;
        rows.push_back(set_expect(r, 32'h200, 32'h100, c_svc, 0, 0, 1));
        rows.push_back(set_expect(r, 32'h204, 32'h104, c_svc, 0, 0, 1));
        rows.push_back(set_expect(r, 32'h208, 32'h200, c_svc, 0, 0, 0));
endtask

// ------------------------------
// Drive and check
// ------------------------------

// All inputs idle, reset held.
task automatic init_inputs;
        i_reset             = 1'b1;
        i_valid             = 1'b0;
        i_code_stall        = 1'b0;
        i_clear_from_alu    = 1'b0;
        i_pc_from_alu       = '0;
        i_clear_from_decode = 1'b0;
        i_pc_from_decode    = '0;
        i_rd_index_0        = '0;
        i_rd_index_1        = '0;
        i_wr_index          = '0;
        i_wr_data           = '0;
        i_flags             = RESET_CPSR;
        i_mem_load          = 1'b0;
        i_wr_index_1        = '0;
        i_wr_data_1         = '0;
        i_fiq               = 1'b0;
        i_irq               = 1'b0;
        i_swi               = 1'b0;
        i_und               = 1'b0;
        i_pc_buf            = '0;
endtask

// Called right after a rising edge.
// Both read ports look at the same index.
task automatic drive_row (input row_t r);
        i_code_stall        <= r.stall;
        i_clear_from_alu    <= r.alu;
        i_pc_from_alu       <= r.alu_pc;
        i_clear_from_decode <= r.dec;
        i_pc_from_decode    <= r.dec_pc;
        i_valid             <= r.valid;
        i_wr_index          <= r.wr_index;
        i_wr_data           <= r.wr_data;
        i_flags             <= r.flags;
        i_mem_load          <= r.mem_load;
        i_wr_index_1        <= r.wr_index_1;
        i_wr_data_1         <= r.wr_data_1;
        i_fiq               <= r.exc.fiq;
        i_irq               <= r.exc.irq;
        i_swi               <= r.exc.swi;
        i_und               <= r.exc.und;
        i_rd_index_0        <= r.rd_index;
        i_rd_index_1        <= r.rd_index;
endtask

// Sampled at the falling edge, when everything is settled.
task automatic check_row (input int n, input row_t r);
        check_word($sformatf("row %0d o_pc_nxt", n), o_pc_nxt, r.exp_pc_nxt);
        check_word($sformatf("row %0d o_pc", n), o_pc, r.exp_pc);
        check_cpsr($sformatf("row %0d o_cpsr", n), o_cpsr, r.exp_cpsr);
        check_bit($sformatf("row %0d o_clear_from_writeback", n),
                  o_clear_from_writeback, r.exp_clear);
        check_bit($sformatf("row %0d o_shelve", n), o_shelve, r.exp_shelve);
        check_bit($sformatf("row %0d o_mask", n), o_mask, r.exp_mask);
        if ( r.chk_rd )
        begin
                check_word($sformatf("row %0d o_rd_data_0", n), o_rd_data_0, r.exp_rd);
                check_word($sformatf("row %0d o_rd_data_1", n), o_rd_data_1, r.exp_rd);
        end
endtask

function automatic logic in_reset_state;
        return o_cpsr === RESET_CPSR && o_pc_nxt === '0 &&
               o_shelve === 1'b0 && o_mask === 1'b0;
endfunction

// Reset state must show before the last reset edge.
// The release edge comes back to the caller, ready for row 0.
task automatic hold_reset (output logic ok);
        int cycles;
        cycles = 0;
        repeat ( RESET_EDGES - 1 ) @(posedge i_clk);
        @(negedge i_clk);
        while ( !in_reset_state() && cycles < RESET_WAIT_LIMIT )
        begin
                @(negedge i_clk);
                cycles++;
        end
        ok = in_reset_state();
        if ( !ok )
        begin
                $display("Timed out waiting for the DUT to show its reset state.");
                timeout_count++;
        end
        else
        begin
                @(posedge i_clk);
                i_reset <= 1'b0;
        end
endtask

task automatic apply_rows;
        foreach ( rows[k] )
        begin
                drive_row(rows[k]);
                @(negedge i_clk);
                check_row(k, rows[k]);
                @(posedge i_clk);
        end
endtask

// ------------------------------
// Main sequence
// ------------------------------

initial
begin
        init_inputs();
        void'($urandom(25));
        build_rows();
        hold_reset(reset_ok);
        if ( reset_ok )
        begin
                apply_rows();
        end

        $display("Summary: %0d rows, %0d mismatches, %0d timeouts",
                 rows.size(), mismatch_count, timeout_count);
        if ( mismatch_count == 0 && timeout_count == 0 )
        begin
                $display("*** TEST PASSED ***");
        end
        else
        begin
                $display("*** TEST FAILED ***");
        end
        $finish;
end

endmodule

// ==== hdl/wb_top.sv ====
// ------------------------------
// Writeback stage top level; packs inputs and wires the stages.
// ------------------------------

module wb_top
(
        input  logic             i_clk,
        input  logic             i_reset,

        // Instruction valid and PC control.
        input  logic             i_valid,
        input  logic             i_code_stall,
        input  logic             i_clear_from_alu,
        input  wb_pkg::word_t    i_pc_from_alu,
        input  logic             i_clear_from_decode,
        input  wb_pkg::word_t    i_pc_from_decode,

        // Read indices.
        input  wb_pkg::reg_idx_t i_rd_index_0,
        input  wb_pkg::reg_idx_t i_rd_index_1,

        // Instruction result.
        input  wb_pkg::reg_idx_t i_wr_index,
        input  wb_pkg::word_t    i_wr_data,
        input  wb_pkg::cpsr_t    i_flags,
        input  logic             i_mem_load,
        input  wb_pkg::reg_idx_t i_wr_index_1,
        input  wb_pkg::word_t    i_wr_data_1,

        // Exceptions and buffered PC.
        input  logic             i_fiq,
        input  logic             i_irq,
        input  logic             i_swi,
        input  logic             i_und,
        input  wb_pkg::word_t    i_pc_buf,

        // Outputs.
        output wb_pkg::word_t    o_rd_data_0,
        output wb_pkg::word_t    o_rd_data_1,
        output wb_pkg::word_t    o_pc,
        output wb_pkg::word_t    o_pc_nxt,
        output wb_pkg::cpsr_t    o_cpsr,
        output logic             o_clear_from_writeback,
        output logic             o_shelve,
        output logic             o_mask
);

import wb_pkg::*;

wb_exc_t    exc;
wb_commit_t commit;
wb_action_t action;
wb_wr_t     wr_a, wr_b;

// Pack loose inputs.
always_comb exc    = '{fiq: i_fiq, irq: i_irq, swi: i_swi, und: i_und};
always_comb commit = '{valid: i_valid, wr_index: i_wr_index, wr_data: i_wr_data,
                       flags: i_flags, mem_load: i_mem_load,
                       wr_index_1: i_wr_index_1, wr_data_1: i_wr_data_1};

wb_event_sel u_event_sel
(
        .i_exc                  (exc),
        .i_commit               (commit),
        .i_pc_buf               (i_pc_buf),
        .o_action               (action),
        .o_clear_from_writeback (o_clear_from_writeback)
);

wb_cpsr_ctl u_cpsr_ctl
(
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_action (action),
        .o_wr_a   (wr_a),
        .o_wr_b   (wr_b),
        .o_cpsr   (o_cpsr)
);

wb_regfile u_regfile
(
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_wr_a       (wr_a),
        .i_wr_b       (wr_b),
        .i_rd_index_0 (i_rd_index_0),
        .i_rd_index_1 (i_rd_index_1),
        .o_rd_data_0  (o_rd_data_0),
        .o_rd_data_1  (o_rd_data_1)
);

wb_pc_seq u_pc_seq
(
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_action            (action),
        .i_code_stall        (i_code_stall),
        .i_clear_from_alu    (i_clear_from_alu),
        .i_pc_from_alu       (i_pc_from_alu),
        .i_clear_from_decode (i_clear_from_decode),
        .i_pc_from_decode    (i_pc_from_decode),
        .o_pc                (o_pc),
        .o_pc_nxt            (o_pc_nxt),
        .o_shelve            (o_shelve),
        .o_mask              (o_mask)
);

endmodule

// ==== hdl/wb_regfile.sv ====
// ------------------------------
// 46-entry register file, two write ports, two async read ports.
// ------------------------------
`include "wb_params.svh"

module wb_regfile
(
        input  logic             i_clk,
        input  logic             i_reset,

        // Write ports; b wins on a clash.
        input  wb_pkg::wb_wr_t   i_wr_a,
        input  wb_pkg::wb_wr_t   i_wr_b,

        // Read ports.
        input  wb_pkg::reg_idx_t i_rd_index_0,
        input  wb_pkg::reg_idx_t i_rd_index_1,
        output wb_pkg::word_t    o_rd_data_0,
        output wb_pkg::word_t    o_rd_data_1
);

import wb_pkg::*;

word_t regs [`WB_PHY_REGS];

// Discard slot and out-of-range reads give zero.
function automatic word_t rd_port (input reg_idx_t idx);
        if ( idx == `WB_PHY_RAZ || idx >= reg_idx_t'(`WB_PHY_REGS) )
        begin
                return '0;
        end
        return regs[idx];
endfunction

always_comb o_rd_data_0 = rd_port(i_rd_index_0);
always_comb o_rd_data_1 = rd_port(i_rd_index_1);

always_ff @ ( posedge i_clk )
begin
        if ( i_reset )
        begin
                for ( int k = 0; k < `WB_PHY_REGS; k++ )
                begin
                        regs[k] <= '0;
                end
        end
        else
        begin
                if ( i_wr_a.en && i_wr_a.addr != `WB_PHY_RAZ )
                begin
                        regs[i_wr_a.addr] <= i_wr_a.data;
                end

                // Later assignment takes the clash.
                if ( i_wr_b.en && i_wr_b.addr != `WB_PHY_RAZ )
                begin
                        regs[i_wr_b.addr] <= i_wr_b.data;
                end
        end
end

// Upstream must never aim a write past the physical file.
assert property ( @(posedge i_clk) disable iff (i_reset)
        (i_wr_a.en -> i_wr_a.addr < `WB_PHY_REGS) &&
        (i_wr_b.en -> i_wr_b.addr < `WB_PHY_REGS) );

endmodule

// ==== hdl/wb_pc_seq.sv ====
// ------------------------------
// PC sequencer with redirects, stall shelving and the mask pulse.
// Runs beside the register path; driven by the same action.
// ------------------------------
`include "wb_params.svh"

module wb_pc_seq
(
        input  logic               i_clk,
        input  logic               i_reset,

        // Writeback redirect.
        input  wb_pkg::wb_action_t i_action,

        // Stall and upstream redirects.
        input  logic               i_code_stall,
        input  logic               i_clear_from_alu,
        input  wb_pkg::word_t      i_pc_from_alu,
        input  logic               i_clear_from_decode,
        input  wb_pkg::word_t      i_pc_from_decode,

        // PC outputs.
        output wb_pkg::word_t      o_pc,
        output wb_pkg::word_t      o_pc_nxt,
        output logic               o_shelve,
        output logic               o_mask
);

import wb_pkg::*;

word_t      pc_ff, pc_nxt;
word_t      pc_del_ff, pc_del_nxt;
word_t      pc_del2_ff, pc_del2_nxt;
word_t      pc_shelve_ff, pc_shelve_nxt;
logic       shelve_ff, shelve_nxt;
logic [1:0] mask_ff, mask_nxt;
logic       redirect;
word_t      target;

always_comb o_pc     = pc_del2_ff;
always_comb o_pc_nxt = pc_ff;
always_comb o_shelve = shelve_ff;
always_comb o_mask   = |mask_ff;

// ------------------------------
// Target select
// ------------------------------

// Writeback first, then ALU, then decode.
always_comb
begin
        redirect = 1'd1;
        target   = i_action.new_pc;

        if ( i_action.redirect )
        begin
                target = i_action.new_pc;
        end
        else if ( i_clear_from_alu )
        begin
                target = i_pc_from_alu;
        end
        else if ( i_clear_from_decode )
        begin
                target = i_pc_from_decode;
        end
        else
        begin
                redirect = 1'd0;
        end
end

// ------------------------------
// Next PC
// ------------------------------

always_comb
begin
        // Hold by default.
        pc_nxt        = pc_ff;
        pc_del_nxt    = pc_del_ff;
        pc_del2_nxt   = pc_del2_ff;
        shelve_nxt    = shelve_ff;
        pc_shelve_nxt = pc_shelve_ff;
        mask_nxt      = mask_ff << 1;

        if ( redirect && i_code_stall )
        begin
                // Park the target until the stall lifts.
                shelve_nxt    = 1'd1;
                pc_shelve_nxt = target;
        end
        else if ( redirect || shelve_ff && !i_code_stall )
        begin
                // Jump to a new or a parked target.
                pc_nxt      = redirect ? target : pc_shelve_ff;
                pc_del_nxt  = pc_ff;
                pc_del2_nxt = pc_del_ff;
                shelve_nxt  = 1'd0;
                mask_nxt    = 2'd1;
        end
        else if ( !i_code_stall )
        begin
                // Plain sequential fetch.
                pc_nxt      = pc_ff + `WB_PC_STEP;
                pc_del_nxt  = pc_ff;
                pc_del2_nxt = pc_del_ff;
        end

        // Halfword bit is never set.
        pc_nxt[0] = 1'd0;
end

always_ff @ ( posedge i_clk )
begin
        if ( i_reset )
        begin
                pc_ff      <= '0;
                pc_del_ff  <= '0;
                pc_del2_ff <= '0;
                shelve_ff  <= 1'd0;
                mask_ff    <= 2'd0;
        end
        else
        begin
                pc_ff      <= pc_nxt;
                pc_del_ff  <= pc_del_nxt;
                pc_del2_ff <= pc_del2_nxt;
                shelve_ff  <= shelve_nxt;
                mask_ff    <= mask_nxt;
        end
end

// Parked target carries no reset.
always_ff @ ( posedge i_clk )
begin
        pc_shelve_ff <= pc_shelve_nxt;
end

endmodule

// ==== hdl/wb_cpsr_ctl.sv ====
// ------------------------------
// Holds the CPSR and turns an action into two register writes.
// ------------------------------
`include "wb_params.svh"

module wb_cpsr_ctl
(
        input  logic               i_clk,
        input  logic               i_reset,

        // Action from event selection.
        input  wb_pkg::wb_action_t i_action,

        // Register file write ports.
        output wb_pkg::wb_wr_t     o_wr_a,
        output wb_pkg::wb_wr_t     o_wr_b,

        // Current status.
        output wb_pkg::cpsr_t      o_cpsr
);

import wb_pkg::*;

// Supervisor mode, both interrupts masked.
localparam cpsr_t cpsr_reset = '{mode: svc, i: 1'b1, f: 1'b1, default: '0};

cpsr_t cpsr_ff, cpsr_nxt;

always_comb o_cpsr = cpsr_ff;

// ------------------------------
// Next state and writes
// ------------------------------

always_comb
begin
        cpsr_nxt = cpsr_ff;
        o_wr_a   = '{en: 1'b0, addr: `WB_PHY_RAZ, data: '0};
        o_wr_b   = '{en: 1'b0, addr: `WB_PHY_RAZ, data: '0};

        case ( i_action.kind )
        ev_fiq, ev_irq, ev_swi, ev_und:
        begin
                // Link on port a, old status to the banked SPSR on port b.
                o_wr_a = '{en: 1'b1, addr: i_action.link_index, data: i_action.link_data};
                o_wr_b = '{en: 1'b1, addr: i_action.spsr_index, data: cpsr_ff};

                // Switch mode, mask IRQ, back to ARM state.
                cpsr_nxt.mode = i_action.new_mode;
                cpsr_nxt.i    = 1'd1;
                cpsr_nxt.t    = 1'd0;

                // FIQ also masks itself.
                if ( i_action.kind == ev_fiq )
                begin
                        cpsr_nxt.f = 1'd1;
                end
        end
        ev_commit:
        begin
                cpsr_nxt = i_action.commit.flags;

                // Load to PC stays in ARM state.
                if ( i_action.redirect )
                begin
                        cpsr_nxt.t = 1'd0;
                end

                // Arithmetic side.
                o_wr_a = '{en: 1'b1, addr: i_action.commit.wr_index,
                           data: i_action.commit.wr_data};

                // Memory side, discarded unless a load.
                o_wr_b = '{en: 1'b1,
                           addr: i_action.commit.mem_load ? i_action.commit.wr_index_1
                                                          : `WB_PHY_RAZ,
                           data: i_action.commit.wr_data_1};
        end
        default:
        begin
                // No update.
        end
        endcase
end

always_ff @ ( posedge i_clk )
begin
        if ( i_reset )
        begin
                cpsr_ff <= cpsr_reset;
        end
        else
        begin
                cpsr_ff <= cpsr_nxt;
        end
end

// Flags loaded from a commit must still name a real mode.
assert property ( @(posedge i_clk) disable iff (i_reset)
        o_cpsr.mode inside {usr, fiq, irq, svc, und} );

endmodule

// ==== hdl/wb_event_sel.sv ====
// ------------------------------
// Resolves exceptions and the commit into one action record.
// Purely combinational; feeds the CPSR control and the PC sequencer.
// ------------------------------
`include "wb_params.svh"

module wb_event_sel
(
        // Exception strobes.
        input  wb_pkg::wb_exc_t    i_exc,

        // Instruction result.
        input  wb_pkg::wb_commit_t i_commit,

        // Buffered PC of the instruction.
        input  wb_pkg::word_t      i_pc_buf,

        // Resolved action and pipeline flush.
        output wb_pkg::wb_action_t o_action,
        output logic               o_clear_from_writeback
);

import wb_pkg::*;

// ------------------------------
// Exception fill
// ------------------------------

// Loads the vector, banked slots and mode into an action.
function automatic wb_action_t take_exc
(
        input wb_action_t base,
        input wb_event_e  kind,
        input word_t      vector,
        input reg_idx_t   r14,
        input reg_idx_t   spsr,
        input cpu_mode_e  mode
);
        wb_action_t act;
        act            = base;
        act.kind       = kind;
        act.redirect   = 1'd1;
        act.new_pc     = vector;
        act.link_index = r14;
        act.spsr_index = spsr;
        act.new_mode   = mode;
        return act;
endfunction

// ------------------------------
// Priority resolve
// ------------------------------

always_comb
begin
        // Idle defaults.
        // Nothing redirects, so the buffered PC rides along.
        o_action            = '0;
        o_action.kind       = ev_none;
        o_action.new_pc     = i_pc_buf;
        o_action.link_index = `WB_PHY_RAZ;
        o_action.link_data  = i_commit.wr_data;
        o_action.spsr_index = `WB_PHY_RAZ;
        o_action.new_mode   = usr;
        o_action.commit     = i_commit;

        if ( i_exc.fiq )
        begin
                o_action = take_exc(o_action, ev_fiq, `WB_FIQ_VECTOR,
                                    `WB_PHY_FIQ_R14, `WB_PHY_FIQ_SPSR, fiq);
        end
        else if ( i_exc.irq )
        begin
                o_action = take_exc(o_action, ev_irq, `WB_IRQ_VECTOR,
                                    `WB_PHY_IRQ_R14, `WB_PHY_IRQ_SPSR, irq);
        end
        else if ( i_exc.swi )
        begin
                o_action = take_exc(o_action, ev_swi, `WB_SWI_VECTOR,
                                    `WB_PHY_SVC_R14, `WB_PHY_SVC_SPSR, svc);
        end
        else if ( i_exc.und )
        begin
                o_action = take_exc(o_action, ev_und, `WB_UND_VECTOR,
                                    `WB_PHY_UND_R14, `WB_PHY_UND_SPSR, und);
        end
        else if ( i_commit.valid )
        begin
                o_action.kind = ev_commit;

                // A load into the PC jumps from here.
                if ( i_commit.mem_load && i_commit.wr_index_1 == `WB_ARCH_PC )
                begin
                        o_action.redirect = 1'd1;
                        o_action.new_pc   = {i_commit.wr_data_1[31:1], 1'd0};
                end
        end
end

// Every writeback redirect flushes the pipe.
always_comb o_clear_from_writeback = o_action.redirect;

endmodule

// ==== hdl/wb_pkg.sv ====
// ------------------------------
// Types shared by every writeback stage and the testbench.
// ------------------------------
`include "wb_params.svh"

package wb_pkg;

// Basic scalars.
typedef logic [`WB_XLEN-1:0]  word_t;
typedef logic [`WB_IDX_W-1:0] reg_idx_t;

// Processor modes, standard encodings.
typedef enum logic [4:0] {
        usr = 5'b10000,
        fiq = 5'b10001,
        irq = 5'b10010,
        svc = 5'b10011,
        und = 5'b11011
} cpu_mode_e;

// Status register layout.
typedef struct packed {
        logic        n;
        logic        z;
        logic        c;
        logic        v;
        logic [19:0] reserved;
        logic        i;
        logic        f;
        logic        t;
        cpu_mode_e   mode;
} cpsr_t;

// Kind of action taken this cycle.
typedef enum logic [2:0] {
        ev_none,
        ev_fiq,
        ev_irq,
        ev_swi,
        ev_und,
        ev_commit
} wb_event_e;

// Exception strobes.
typedef struct packed {
        logic fiq;
        logic irq;
        logic swi;
        logic und;
} wb_exc_t;

// Result of the instruction at hand.
typedef struct packed {
        logic     valid;
        reg_idx_t wr_index;
        word_t    wr_data;
        cpsr_t    flags;
        logic     mem_load;
        reg_idx_t wr_index_1;
        word_t    wr_data_1;
} wb_commit_t;

// Resolved action.
typedef struct packed {
        wb_event_e  kind;
        logic       redirect;
        word_t      new_pc;
        reg_idx_t   link_index;
        word_t      link_data;
        reg_idx_t   spsr_index;
        cpu_mode_e  new_mode;
        wb_commit_t commit;
} wb_action_t;

// One register file write.
typedef struct packed {
        logic     en;
        reg_idx_t addr;
        word_t    data;
} wb_wr_t;

endpackage

// ==== include/wb_params.svh ====
// ------------------------------
// Widths, register map and vectors for the writeback stage.
// Include wherever a value below is needed.
// ------------------------------
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// Data word and register file size.
`define WB_XLEN          32
`define WB_PHY_REGS      46
`define WB_IDX_W         6

// Architectural PC and the read-as-zero slot.
`define WB_ARCH_PC       6'd15
`define WB_PHY_RAZ       6'd16

// Banked link registers.
`define WB_PHY_FIQ_R14   6'd23
`define WB_PHY_IRQ_R14   6'd25
`define WB_PHY_SVC_R14   6'd27
`define WB_PHY_UND_R14   6'd29

// Banked saved status registers.
`define WB_PHY_FIQ_SPSR  6'd34
`define WB_PHY_IRQ_SPSR  6'd35
`define WB_PHY_SVC_SPSR  6'd36
`define WB_PHY_UND_SPSR  6'd37

// Exception vectors.
`define WB_UND_VECTOR    32'h0000_0004
`define WB_SWI_VECTOR    32'h0000_0008
`define WB_IRQ_VECTOR    32'h0000_0018
`define WB_FIQ_VECTOR    32'h0000_001C

// Sequential fetch increment.
`define WB_PC_STEP       32'd4

`endif
